// File: Bender.yml
package:
  name: ks10Dbus

sources:
  - design/ks10Pkg.sv
  - design/microStepIf.sv
  - design/cromLatch.sv
  - design/ramfile.sv
  - design/dbusStage.sv
  - design/ks10Dbus.sv
  - target: test
    files:
      - verification/dbusTb.sv

// File: design/cromLatch.sv
// CROM latch for the data-bus slice.
// Captures a strobed microword with its operands and presents the
// decoded step for exactly one cycle after the strobe.

`timescale 1ns/1ps
`default_nettype none

module cromLatch #(
   parameter int rfAddrWidth = 4
) (
   input  wire logic                                        clk,
   input  wire logic                                        rstN,
   input  wire logic                                        cromStrobe,
   input  wire logic [0:ks10Pkg::cromWidth-1]               cromWord,
   input  wire logic [ks10Pkg::vmaAddrFirst:ks10Pkg::wordWidth-1] vmaAddr,
   input  wire logic [0:ks10Pkg::vmaFlagsWidth-1]           vmaFlags,
   input  wire logic                                        cacheHit,
   input  wire logic [0:ks10Pkg::reqIntpWidth-1]            reqIntp,
   input  wire logic [0:ks10Pkg::pcFlagsWidth-1]            pcFlags,
   input  wire logic [0:ks10Pkg::wordWidth-1]               dp,
   input  wire logic [0:ks10Pkg::wordWidth-1]               dbm,
   microStepIf.producer                                     step
);

   import ks10Pkg::*;

   // Ramfile address candidates
   logic [0:rfAddrWidth-1] acAddr;
   logic [0:rfAddrWidth-1] vmaLowAddr;

   ////////////////////
   // Address select
   ////////////////////

   // Zero-extend the 4-bit sources to the ramfile width
   assign acAddr     = rfAddrWidth'(cromWord[acFieldFirst:acFieldLast]);
   // Low VMA bits address an AC
   assign vmaLowAddr = rfAddrWidth'(vmaAddr[32:35]);

   ////////////////////
   // Step valid
   ////////////////////

   // One cycle per strobe, strobes may come back to back
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
         step.stepValid <= 1'b0;
      else
         step.stepValid <= cromStrobe;
   end

   ////////////////////
   // Fields and operands
   ////////////////////

   // Payload only loads on a strobe
   always_ff @(posedge clk)
   begin
      if (cromStrobe)
      begin
         step.cromAddr  <= cromWord[cromAddrFirst:cromAddrLast];
         step.dbusSel   <= dbusSelT'(cromWord[dbusSelFirst:dbusSelLast]);
         step.rfWrite   <= cromWord[rfWriteBit];
         step.rfAddr    <= cromWord[rfAddrSelBit] ? vmaLowAddr : acAddr;
         // VMA flag decode
         step.readCycle <= vmaFlags[vmaReadCycleBit];
         step.physical  <= vmaFlags[vmaPhysicalBit];
         step.vmaAddr   <= vmaAddr;
         step.cacheHit  <= cacheHit;
         step.reqIntp   <= reqIntp;
         step.pcFlags   <= pcFlags;
         step.dp        <= dp;
         step.dbm       <= dbm;
      end
   end

endmodule

`default_nettype wire

// File: design/dbusStage.sv
// DBUS mux stage.
// Forms the data bus during a valid step from flags, datapath, ramfile
// or DBM, applying the ramfile force rule, then registers it.
// The combinational bus also feeds the ramfile write port.

`timescale 1ns/1ps
`default_nettype none

module dbusStage #(
   parameter int rfAddrWidth = 4
) (
   input  wire logic                            clk,
   input  wire logic                            rstN,
   microStepIf.consumer                         step,
   input  wire logic [0:ks10Pkg::wordWidth-1]   rfData,
   output logic      [0:ks10Pkg::wordWidth-1]   busValue,
   output logic                                 dbusValid,
   output logic      [0:ks10Pkg::wordWidth-1]   dbus
);

   import ks10Pkg::*;

   logic                 acRef;
   logic                 noForceAddr;
   logic                 forceRamfile;
   logic [0:wordWidth-1] flagsWord;

   // Forced AC reads need all 16 ACs in the ramfile
   if (rfAddrWidth < 4)
   begin : gAddrCheck
      $error("dbusStage: ramfile too small for accumulators");
   end

   ////////////////////
   // Force rule
   ////////////////////

   // AC reference, lowest 16 addresses and never physical
   assign acRef = ~step.physical & (step.vmaAddr[18:31] == '0);

   // Two microcode locations skip the AC force
   assign noForceAddr = (step.cromAddr == noForceAddrA) |
                        (step.cromAddr == noForceAddrB);

   // Read cycle takes the ramfile in place of memory
   assign forceRamfile = (acRef & step.readCycle & ~noForceAddr) |
                         (step.cacheHit & step.readCycle);

   ////////////////////
   // Bus mux
   ////////////////////

   // PC flags, a zero, PI level, four ones, low VMA bits
   assign flagsWord = {step.pcFlags, 1'b0, step.reqIntp, 4'b1111,
                       step.vmaAddr[26:35]};

   always_comb
   begin
      case (step.dbusSel)
         selFlags:   busValue = flagsWord;
         selDp:      busValue = step.dp;
         selRamfile: busValue = rfData;
         // DBM unless the force rule picks the ramfile
         selDbm:     busValue = forceRamfile ? rfData : step.dbm;
         default:    busValue = step.dbm;
      endcase
   end

   ////////////////////
   // Output register
   ////////////////////

   // Valid for one cycle, bus held until the next step
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         dbusValid <= 1'b0;
         dbus      <= '0;
      end
      else
      begin
         dbusValid <= step.stepValid;
         if (step.stepValid)
            dbus <= busValue;
      end
   end

endmodule

`default_nettype wire

// File: design/ks10Dbus.sv
// Top level of the KS10 data-bus slice.
// Strobe a microword with its operands; dbus appears with dbusValid
// two cycles later. Steps may be strobed on every cycle.

`timescale 1ns/1ps
`default_nettype none

module ks10Dbus #(
   parameter int rfAddrWidth = 4
) (
   input  wire logic                                        clk,
   input  wire logic                                        rstN,
   input  wire logic                                        cromStrobe,
   input  wire logic [0:ks10Pkg::cromWidth-1]               cromWord,
   input  wire logic [ks10Pkg::vmaAddrFirst:ks10Pkg::wordWidth-1] vmaAddr,
   input  wire logic [0:ks10Pkg::vmaFlagsWidth-1]           vmaFlags,
   input  wire logic                                        cacheHit,
   input  wire logic [0:ks10Pkg::reqIntpWidth-1]            reqIntp,
   input  wire logic [0:ks10Pkg::pcFlagsWidth-1]            pcFlags,
   input  wire logic [0:ks10Pkg::wordWidth-1]               dp,
   input  wire logic [0:ks10Pkg::wordWidth-1]               dbm,
   output logic                                             dbusValid,
   output logic      [0:ks10Pkg::wordWidth-1]               dbus
);

   import ks10Pkg::*;

   // Ramfile read word and bus write data
   logic [0:wordWidth-1] rfData;
   logic [0:wordWidth-1] busValue;

   microStepIf #(.rfAddrWidth(rfAddrWidth)) step ();

   ////////////////////
   // Producer
   ////////////////////

   cromLatch #(.rfAddrWidth(rfAddrWidth)) uCromLatch (
      .clk        (clk),
      .rstN       (rstN),
      .cromStrobe (cromStrobe),
      .cromWord   (cromWord),
      .vmaAddr    (vmaAddr),
      .vmaFlags   (vmaFlags),
      .cacheHit   (cacheHit),
      .reqIntp    (reqIntp),
      .pcFlags    (pcFlags),
      .dp         (dp),
      .dbm        (dbm),
      .step       (step.producer)
   );

   ////////////////////
   // Ramfile and bus
   ////////////////////

   ramfile #(.rfAddrWidth(rfAddrWidth)) uRamfile (
      .clk       (clk),
      .rstN      (rstN),
      .step      (step.store),
      .writeData (busValue),
      .readData  (rfData)
   );

   dbusStage #(.rfAddrWidth(rfAddrWidth)) uDbusStage (
      .clk       (clk),
      .rstN      (rstN),
      .step      (step.consumer),
      .rfData    (rfData),
      .busValue  (busValue),
      .dbusValid (dbusValid),
      .dbus      (dbus)
   );

endmodule

`default_nettype wire

// File: design/ks10Pkg.sv
// Shared constants and types for the KS10 data-bus slice.
// Bit numbering is MSB first from 0, as in the processor prints.
// Module headers use ks10Pkg:: names; bodies import the package.

`default_nettype none

package ks10Pkg;

   ////////////////////
   // Word sizes
   ////////////////////

   // Machine word and control ROM microword
   localparam int wordWidth = 36;
   localparam int cromWidth = 24;

   // Microword fields, MSB first
   localparam int cromAddrFirst = 0;
   localparam int cromAddrLast  = 11;
   localparam int dbusSelFirst  = 12;
   localparam int dbusSelLast   = 13;
   localparam int rfWriteBit    = 14;
   // 0 picks the AC field, 1 picks the low VMA bits
   localparam int rfAddrSelBit  = 15;
   localparam int acFieldFirst  = 16;
   localparam int acFieldLast   = 19;
   // Bits 20 to 23 spare

   // DBUS select codes
   typedef enum logic [1:0] {
      selFlags,
      selDp,
      selRamfile,
      selDbm
   } dbusSelT;

   ////////////////////
   // VMA and PC
   ////////////////////

   localparam int vmaFlagsWidth   = 14;
   localparam int vmaReadCycleBit = 3;
   localparam int vmaPhysicalBit  = 8;
   // VMA address covers bits 14 to 35
   localparam int vmaAddrWidth    = 22;
   localparam int vmaAddrFirst    = wordWidth - vmaAddrWidth;
   localparam int pcFlagsWidth    = 18;
   localparam int reqIntpWidth    = 3;

   // Microcode addresses exempt from the AC force
   localparam logic [cromAddrFirst:cromAddrLast] noForceAddrA = 12'o1146;
   localparam logic [cromAddrFirst:cromAddrLast] noForceAddrB = 12'o3666;

endpackage

`default_nettype wire

// File: design/microStepIf.sv
// One latched microstep with its operands.
// Driven by the CROM latch, read by the DBUS stage and the ramfile.

`timescale 1ns/1ps
`default_nettype none

interface microStepIf #(
   parameter int rfAddrWidth = 4
) ();

   import ks10Pkg::*;

   // High for one cycle per step
   logic                                 stepValid;
   dbusSelT                              dbusSel;
   logic                                 rfWrite;
   logic [0:rfAddrWidth-1]               rfAddr;
   logic [cromAddrFirst:cromAddrLast]    cromAddr;

   // Memory side
   logic [vmaAddrFirst:wordWidth-1]      vmaAddr;
   logic                                 readCycle;
   logic                                 physical;
   logic                                 cacheHit;

   // Flag word sources and data
   logic [0:reqIntpWidth-1]              reqIntp;
   logic [0:pcFlagsWidth-1]              pcFlags;
   logic [0:wordWidth-1]                 dp;
   logic [0:wordWidth-1]                 dbm;

   modport producer (
      output stepValid, dbusSel, rfWrite, rfAddr, cromAddr, vmaAddr,
             readCycle, physical, cacheHit, reqIntp, pcFlags, dp, dbm
   );

   modport consumer (
      input  stepValid, dbusSel, rfWrite, rfAddr, cromAddr, vmaAddr,
             readCycle, physical, cacheHit, reqIntp, pcFlags, dp, dbm
   );

   // Ramfile only needs address and write control
   modport store (
      input  rfAddr, rfWrite, stepValid
   );

endinterface

`default_nettype wire

// File: design/ramfile.sv
// Accumulator ramfile.
// Combinational read at the step address; the bus value is written
// at the end of a valid step that has rfWrite set.

`timescale 1ns/1ps
`default_nettype none

module ramfile #(
   parameter int rfAddrWidth = 4
) (
   input  wire logic                            clk,
   input  wire logic                            rstN,
   microStepIf.store                            step,
   input  wire logic [0:ks10Pkg::wordWidth-1]   writeData,
   output logic      [0:ks10Pkg::wordWidth-1]   readData
);

   import ks10Pkg::*;

   // Words above 15 reserved for wider variants
   localparam int rfDepth = 2 ** rfAddrWidth;

   logic [0:wordWidth-1] rfMem [0:rfDepth-1];
   logic                 rfWe;

   ////////////////////
   // Write port
   ////////////////////

   assign rfWe = step.stepValid & step.rfWrite;

   // All ACs read as zero after reset
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         for (int i = 0; i < rfDepth; i++)
            rfMem[i] <= '0;
      end
      else if (rfWe)
      begin
         rfMem[step.rfAddr] <= writeData;
      end
   end

   ////////////////////
   // Read port
   ////////////////////

   // Sees a write from the previous step
   assign readData = rfMem[step.rfAddr];

endmodule

`default_nettype wire

// File: project.f
design/ks10Pkg.sv
design/microStepIf.sv
design/cromLatch.sv
design/ramfile.sv
design/dbusStage.sv
design/ks10Dbus.sv
verification/dbusTb.sv

// File: verification/dbusTb.sv
// Directed testbench for the KS10 data-bus slice.
// Each test task strobes microsteps; a shadow ramfile model predicts dbus,
// and a negedge checker compares each valid result and its arrival cycle.

`timescale 1ns/1ps
`default_nettype none

module dbusTb;

   import ks10Pkg::*;

   localparam int maxCycles = 2000;

   logic                          clk;
   logic                          rstN;
   logic                          cromStrobe;
   logic [0:cromWidth-1]          cromWord;
   logic [vmaAddrFirst:wordWidth-1] vmaAddr;
   logic [0:vmaFlagsWidth-1]      vmaFlags;
   logic                          cacheHit;
   logic [0:reqIntpWidth-1]       reqIntp;
   logic [0:pcFlagsWidth-1]       pcFlags;
   logic [0:wordWidth-1]          dp;
   logic [0:wordWidth-1]          dbm;
   logic                          dbusValid;
   logic [0:wordWidth-1]          dbus;

   // Shadow ACs and results in flight
   logic [0:wordWidth-1] shadowRf [0:15];
   logic [0:wordWidth-1] expData [$];
   int                   expCycle [$];
   logic [0:wordWidth-1] expWord;
   int                   expAt;
   int                   cycleCount = 0;
   int                   errorCount = 0;
   int                   checkCount = 0;

   ks10Dbus #(.rfAddrWidth(4)) DUT (
      .clk(clk), .rstN(rstN), .cromStrobe(cromStrobe), .cromWord(cromWord),
      .vmaAddr(vmaAddr), .vmaFlags(vmaFlags), .cacheHit(cacheHit),
      .reqIntp(reqIntp), .pcFlags(pcFlags), .dp(dp), .dbm(dbm),
      .dbusValid(dbusValid), .dbus(dbus)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
      cycleCount <= cycleCount + 1;

   // Hard stop well past the length of all tests
   initial
   begin
      repeat (maxCycles) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", maxCycles);
      $display("*** FAILED ***");
      $finish;
   end

   ////////////////////
   // Reference model
   ////////////////////

   // Bus value from the current inputs and shadow ACs
   function automatic logic [0:wordWidth-1] modelBus(input logic [0:3] rfA);
      logic acRef;
      logic forceRf;
      logic [0:wordWidth-1] rfWord;
      rfWord = shadowRf[rfA];
      acRef = !vmaFlags[8] && (vmaAddr[18:31] == 14'd0);
      forceRf = vmaFlags[3] && (cacheHit ||
                (acRef && cromWord[0:11] != 12'o1146 && cromWord[0:11] != 12'o3666));
      case (cromWord[12:13])
         2'd0:    return {pcFlags, 1'b0, reqIntp, 4'b1111, vmaAddr[26:35]};
         2'd1:    return dp;
         2'd2:    return rfWord;
         default: return forceRf ? rfWord : dbm;
      endcase
   endfunction

   function automatic logic [0:wordWidth-1] randWord();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[35:0];
   endfunction

   ////////////////////
   // Drive and check
   ////////////////////

   // Called 2 ns after a rising edge, returns 2 ns after the next one
   task automatic issueStep(input logic [0:11] addr, input logic [1:0] sel,
                            input logic wr, input logic asel, input logic [0:3] ac,
                            input logic [14:35] vma, input logic rd,
                            input logic phys, input logic hit);
      logic [31:0] r;
      logic [0:3] rfA;
      logic [0:wordWidth-1] predicted;
      r = $urandom();
      dp = randWord();
      dbm = randWord();
      pcFlags = r[17:0];
      reqIntp = r[20:18];
      cromWord = {addr, sel, wr, asel, ac, 4'b0000};
      vmaAddr = vma;
      vmaFlags = '0;
      vmaFlags[3] = rd;
      vmaFlags[8] = phys;
      cacheHit = hit;
      cromStrobe = 1'b1;
      rfA = asel ? vma[32:35] : ac;
      predicted = modelBus(rfA);
      // Write lands before the next step reads
      if (wr)
         shadowRf[rfA] = predicted;
      expData.push_back(predicted);
      expCycle.push_back(cycleCount + 2);
      @(posedge clk);
      #2;
      cromStrobe = 1'b0;
   endtask

   task automatic waitDrain();
      while (expData.size() != 0)
         @(posedge clk);
      #2;
   endtask

   task automatic checkIdle();
      checkCount++;
      if (dbusValid !== 1'b0)
      begin
         errorCount++;
         $display("Fail at %0t: dbusValid got %b expected 0", $time, dbusValid);
      end
      if (dbus !== '0)
      begin
         errorCount++;
         $display("Fail at %0t: dbus got %h expected 0", $time, dbus);
      end
   endtask

   // Every valid result against the oldest prediction
   always @(negedge clk)
   begin
      if (rstN && dbusValid)
      begin
         if (expData.size() == 0)
         begin
            errorCount++;
            $display("Error at %0t: dbusValid high with no step in flight", $time);
         end
         else
         begin
            expWord = expData.pop_front();
            expAt = expCycle.pop_front();
            checkCount++;
            if (dbus !== expWord)
            begin
               errorCount++;
               $display("Fail at %0t: dbus got %h expected %h", $time, dbus, expWord);
            end
            if (cycleCount != expAt)
            begin
               errorCount++;
               $display("Fail at %0t: dbusValid cycle got %0d expected %0d",
                        $time, cycleCount, expAt);
            end
         end
      end
   end

   ////////////////////
   // Tests
   ////////////////////

   task automatic testReset();
      repeat (4)
      begin
         @(posedge clk);
         #1;
         checkIdle();
      end
      #1;
      rstN = 1'b1;
      // Still quiet before any strobe
      repeat (3)
      begin
         @(negedge clk);
         checkIdle();
      end
      @(posedge clk);
      #2;
   endtask

   task automatic testPassThrough();
      issueStep(12'o0100, selDp, 1'b0, 1'b0, 4'd0, 22'h0, 1'b0, 1'b0, 1'b0);
      issueStep(12'o0101, selDbm, 1'b0, 1'b0, 4'd2, 22'h000002, 1'b0, 1'b0, 1'b0);
      // Physical access is never an AC reference
      issueStep(12'o0102, selDbm, 1'b0, 1'b0, 4'd2, 22'h000002, 1'b1, 1'b1, 1'b0);
      waitDrain();
   endtask

   task automatic testFlags();
      logic [31:0] r;
      repeat (4)
      begin
         r = $urandom();
         issueStep(12'o0110, selFlags, 1'b0, 1'b0, 4'd0, r[21:0], 1'b0, 1'b0, 1'b0);
      end
      waitDrain();
   endtask

   task automatic testRamfileWrite();
      issueStep(12'o0200, selDp, 1'b1, 1'b0, 4'd7, 22'h0, 1'b0, 1'b0, 1'b0);
      issueStep(12'o0201, selRamfile, 1'b0, 1'b0, 4'd7, 22'h0, 1'b0, 1'b0, 1'b0);
      // AC5 through the VMA address path
      issueStep(12'o0202, selDp, 1'b1, 1'b1, 4'd0, 22'h000005, 1'b0, 1'b0, 1'b0);
      issueStep(12'o0203, selRamfile, 1'b0, 1'b1, 4'd0, 22'h000005, 1'b0, 1'b0, 1'b0);
      waitDrain();
   endtask

   task automatic testForceRule();
      issueStep(12'o0300, selDbm, 1'b0, 1'b1, 4'd0, 22'h000007, 1'b1, 1'b0, 1'b0);
      issueStep(12'o1146, selDbm, 1'b0, 1'b1, 4'd0, 22'h000007, 1'b1, 1'b0, 1'b0);
      issueStep(12'o3666, selDbm, 1'b0, 1'b1, 4'd0, 22'h000007, 1'b1, 1'b0, 1'b0);
      // Cache hit outside the AC range
      issueStep(12'o0301, selDbm, 1'b0, 1'b1, 4'd0, 22'h3F0005, 1'b1, 1'b0, 1'b1);
      waitDrain();
   endtask

   task automatic testBackToBack();
      logic [31:0] r;
      logic [31:0] v;
      logic [14:35] vma;
      logic [0:11] addr;
      repeat (20)
      begin
         r = $urandom();
         v = $urandom();
         vma = r[6] ? {20'd0, r[8:7]} : v[21:0];
         addr = r[13] ? 12'o1146 : r[25:14];
         issueStep(addr, r[1:0], r[2], r[3], {2'b00, r[5:4]}, vma,
                   r[9], r[10] & r[11], r[12]);
      end
      waitDrain();
   endtask

   initial
   begin
      void'($urandom(15));
      for (int i = 0; i < 16; i++)
         shadowRf[i] = '0;
      rstN = 1'b0;
      cromStrobe = 1'b0;
      cromWord = '0;
      vmaAddr = '0;
      vmaFlags = '0;
      cacheHit = 1'b0;
      reqIntp = '0;
      pcFlags = '0;
      dp = '0;
      dbm = '0;

      testReset();
      testPassThrough();
      testFlags();
      testRamfileWrite();
      testForceRule();
      testBackToBack();
      repeat (3) @(posedge clk);

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire
